// ==== src/axil_xbar_pkg.sv ====
package axil_xbar_pkg;

    ////////////////////////////////////////////////////////////
    // Payload widths
    ////////////////////////////////////////////////////////////

    // Byte address of a write
    typedef logic [31:0] addr_t;

    // Write data word and its byte lanes
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // AXI B channel response
    typedef logic [1:0]  resp_t;

    ////////////////////////////////////////////////////////////
    // Response codes
    ////////////////////////////////////////////////////////////

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    ////////////////////////////////////////////////////////////
    // Router FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FWD,
        ST_RESP
    } router_state_t;

endpackage

// ==== src/axil_wr_arbiter.sv ====
module axil_wr_arbiter #(
    parameter  int NUMBER_MASTER = 2,
    localparam int IDX_W         = (NUMBER_MASTER > 1) ? $clog2(NUMBER_MASTER) : 1
) (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic [NUMBER_MASTER-1:0] m_awvalid,
    input  logic                     txn_done,
    output logic                     grant_valid,
    output logic [IDX_W-1:0]         grant_idx
);

    // Held from grant until the write completes
    logic             locked;
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] next_ptr;

    logic [IDX_W-1:0] pick_idx;
    logic             pick_found;

    ////////////////////////////////////////////////////////////
    // Round-robin pick
    ////////////////////////////////////////////////////////////

    // First requesting master at or after the pointer
    always_comb begin
        int cand;
        pick_idx   = '0;
        pick_found = 1'b0;
        for (int k = 0; k < NUMBER_MASTER; k++) begin
            cand = int'(rr_ptr) + k;
            if (cand >= NUMBER_MASTER) begin
                cand = cand - NUMBER_MASTER;
            end
            if (!pick_found && m_awvalid[cand]) begin
                pick_found = 1'b1;
                pick_idx   = IDX_W'(cand);
            end
        end
    end

    // One past the winner, wrapping at the last master
    assign next_ptr = (int'(grant_idx) == NUMBER_MASTER - 1) ? '0 : grant_idx + 1'b1;

    ////////////////////////////////////////////////////////////
    // Grant lock
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            locked    <= 1'b0;
            grant_idx <= '0;
            rr_ptr    <= '0;
        end else if (!locked) begin
            if (pick_found) begin
                locked    <= 1'b1;
                grant_idx <= pick_idx;
            end
        end else if (txn_done) begin
            // Winner drops to lowest priority
            locked <= 1'b0;
            rr_ptr <= next_ptr;
        end
    end

    assign grant_valid = locked;

endmodule

// ==== src/axil_wr_router.sv ====
module axil_wr_router #(
    parameter  int                   NUMBER_MASTER = 2,
    parameter  int                   NUMBER_SLAVE  = 2,
    parameter  axil_xbar_pkg::addr_t ADDR_OFFSET [NUMBER_SLAVE] = '{32'h0000_0000,
                                                                     32'h1000_0000},
    parameter  axil_xbar_pkg::addr_t ADDR_RANGE  [NUMBER_SLAVE] = '{32'h0FFF_FFFF,
                                                                     32'h0FFF_FFFF},
    localparam int MIDX_W = (NUMBER_MASTER > 1) ? $clog2(NUMBER_MASTER) : 1,
    localparam int SIDX_W = (NUMBER_SLAVE > 1) ? $clog2(NUMBER_SLAVE) : 1
) (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     grant_valid,
    input  logic [MIDX_W-1:0]        grant_idx,
    output logic                     txn_done,

    // Masters
    input  axil_xbar_pkg::addr_t     m_axil_awaddr [NUMBER_MASTER],
    input  logic [NUMBER_MASTER-1:0] m_axil_awvalid,
    output logic [NUMBER_MASTER-1:0] m_axil_awready,
    input  axil_xbar_pkg::data_t     m_axil_wdata  [NUMBER_MASTER],
    input  axil_xbar_pkg::strb_t     m_axil_wstrb  [NUMBER_MASTER],
    input  logic [NUMBER_MASTER-1:0] m_axil_wvalid,
    output logic [NUMBER_MASTER-1:0] m_axil_wready,
    output axil_xbar_pkg::resp_t     m_axil_bresp  [NUMBER_MASTER],
    output logic [NUMBER_MASTER-1:0] m_axil_bvalid,
    input  logic [NUMBER_MASTER-1:0] m_axil_bready,

    // Slaves
    output axil_xbar_pkg::addr_t     s_axil_awaddr [NUMBER_SLAVE],
    output logic [NUMBER_SLAVE-1:0]  s_axil_awvalid,
    input  logic [NUMBER_SLAVE-1:0]  s_axil_awready,
    output axil_xbar_pkg::data_t     s_axil_wdata  [NUMBER_SLAVE],
    output axil_xbar_pkg::strb_t     s_axil_wstrb  [NUMBER_SLAVE],
    output logic [NUMBER_SLAVE-1:0]  s_axil_wvalid,
    input  logic [NUMBER_SLAVE-1:0]  s_axil_wready,
    input  axil_xbar_pkg::resp_t     s_axil_bresp  [NUMBER_SLAVE],
    input  logic [NUMBER_SLAVE-1:0]  s_axil_bvalid,
    output logic [NUMBER_SLAVE-1:0]  s_axil_bready,

    // Decode-error slave
    output axil_xbar_pkg::addr_t     err_awaddr,
    output logic                     err_awvalid,
    input  logic                     err_awready,
    output axil_xbar_pkg::data_t     err_wdata,
    output axil_xbar_pkg::strb_t     err_wstrb,
    output logic                     err_wvalid,
    input  logic                     err_wready,
    input  axil_xbar_pkg::resp_t     err_bresp,
    input  logic                     err_bvalid,
    output logic                     err_bready
);

    axil_xbar_pkg::router_state_t state;
    logic [SIDX_W-1:0]            tgt_idx;
    logic                         tgt_miss;
    logic                         aw_done;
    logic                         w_done;

    logic [SIDX_W-1:0]            dec_idx;
    logic                         dec_hit;

    logic                         tgt_awready;
    logic                         tgt_wready;
    logic                         tgt_bvalid;
    axil_xbar_pkg::resp_t         tgt_bresp;

    logic                         fwd_awvalid;
    logic                         fwd_wvalid;
    logic                         fwd_bready;
    logic                         aw_hs;
    logic                         w_hs;

    ////////////////////////////////////////////////////////////
    // Address decode, lowest window wins
    ////////////////////////////////////////////////////////////

    always_comb begin
        axil_xbar_pkg::addr_t addr;
        addr    = m_axil_awaddr[grant_idx];
        dec_idx = '0;
        dec_hit = 1'b0;
        for (int k = 0; k < NUMBER_SLAVE; k++) begin
            // Offset subtracted first so the window end cannot overflow
            if (!dec_hit && addr >= ADDR_OFFSET[k] &&
                (addr - ADDR_OFFSET[k]) <= ADDR_RANGE[k]) begin
                dec_hit = 1'b1;
                dec_idx = SIDX_W'(k);
            end
        end
    end

    // Ready and response of the latched target
    always_comb begin
        if (tgt_miss) begin
            tgt_awready = err_awready;
            tgt_wready  = err_wready;
            tgt_bvalid  = err_bvalid;
            tgt_bresp   = err_bresp;
        end else begin
            tgt_awready = s_axil_awready[tgt_idx];
            tgt_wready  = s_axil_wready[tgt_idx];
            tgt_bvalid  = s_axil_bvalid[tgt_idx];
            tgt_bresp   = s_axil_bresp[tgt_idx];
        end
    end

    assign fwd_awvalid = (state == axil_xbar_pkg::ST_FWD) && !aw_done &&
                         m_axil_awvalid[grant_idx];
    assign fwd_wvalid  = (state == axil_xbar_pkg::ST_FWD) && !w_done &&
                         m_axil_wvalid[grant_idx];
    assign fwd_bready  = (state == axil_xbar_pkg::ST_RESP) && m_axil_bready[grant_idx];

    assign aw_hs    = fwd_awvalid && tgt_awready;
    assign w_hs     = fwd_wvalid && tgt_wready;
    assign txn_done = fwd_bready && tgt_bvalid;

    ////////////////////////////////////////////////////////////
    // Channel steering
    ////////////////////////////////////////////////////////////

    always_comb begin
        m_axil_awready = '0;
        m_axil_wready  = '0;
        m_axil_bvalid  = '0;
        for (int i = 0; i < NUMBER_MASTER; i++) begin
            m_axil_bresp[i] = axil_xbar_pkg::RESP_OKAY;
        end
        if (state == axil_xbar_pkg::ST_FWD) begin
            m_axil_awready[grant_idx] = !aw_done && tgt_awready;
            m_axil_wready[grant_idx]  = !w_done && tgt_wready;
        end
        if (state == axil_xbar_pkg::ST_RESP) begin
            m_axil_bvalid[grant_idx] = tgt_bvalid;
            m_axil_bresp[grant_idx]  = tgt_bresp;
        end
    end

    // Payload goes to every slave, only the target sees valid
    always_comb begin
        for (int k = 0; k < NUMBER_SLAVE; k++) begin
            s_axil_awaddr[k] = m_axil_awaddr[grant_idx];
            s_axil_wdata[k]  = m_axil_wdata[grant_idx];
            s_axil_wstrb[k]  = m_axil_wstrb[grant_idx];
        end
        err_awaddr     = m_axil_awaddr[grant_idx];
        err_wdata      = m_axil_wdata[grant_idx];
        err_wstrb      = m_axil_wstrb[grant_idx];
        s_axil_awvalid = '0;
        s_axil_wvalid  = '0;
        s_axil_bready  = '0;
        err_awvalid    = 1'b0;
        err_wvalid     = 1'b0;
        err_bready     = 1'b0;
        if (tgt_miss) begin
            err_awvalid = fwd_awvalid;
            err_wvalid  = fwd_wvalid;
            err_bready  = fwd_bready;
        end else begin
            s_axil_awvalid[tgt_idx] = fwd_awvalid;
            s_axil_wvalid[tgt_idx]  = fwd_wvalid;
            s_axil_bready[tgt_idx]  = fwd_bready;
        end
    end

    ////////////////////////////////////////////////////////////
    // Write sequence FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= axil_xbar_pkg::ST_IDLE;
            tgt_idx  <= '0;
            tgt_miss <= 1'b0;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
        end else begin
            case (state)
                axil_xbar_pkg::ST_IDLE: begin
                    if (grant_valid) begin
                        tgt_idx  <= dec_idx;
                        tgt_miss <= !dec_hit;
                        state    <= axil_xbar_pkg::ST_FWD;
                    end
                end
                axil_xbar_pkg::ST_FWD: begin
                    if (aw_hs) begin
                        aw_done <= 1'b1;
                    end
                    if (w_hs) begin
                        w_done <= 1'b1;
                    end
                    // AW and W may finish in either order
                    if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= axil_xbar_pkg::ST_RESP;
                    end
                end
                axil_xbar_pkg::ST_RESP: begin
                    if (txn_done) begin
                        state <= axil_xbar_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= axil_xbar_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/axil_wr_decerr_slave.sv ====
module axil_wr_decerr_slave (
    input  logic                 aclk,
    input  logic                 rst,

    // Write address
    input  axil_xbar_pkg::addr_t awaddr,
    input  logic                 awvalid,
    output logic                 awready,

    // Write data
    input  axil_xbar_pkg::data_t wdata,
    input  axil_xbar_pkg::strb_t wstrb,
    input  logic                 wvalid,
    output logic                 wready,

    // Write response
    output axil_xbar_pkg::resp_t bresp,
    output logic                 bvalid,
    input  logic                 bready
);

    // Beat accepted on each channel
    logic aw_acc;
    logic w_acc;

    logic aw_hs;
    logic w_hs;
    logic b_hs;

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    // Address, data and strobes are taken and then dropped,
    // nothing reaches any storage
    assign awready = !aw_acc;
    assign wready  = !w_acc;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    // Response once both beats are in
    assign bvalid = aw_acc && w_acc;
    assign bresp  = axil_xbar_pkg::RESP_DECERR;

    ////////////////////////////////////////////////////////////
    // Accept flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            aw_acc <= 1'b0;
            w_acc  <= 1'b0;
        end else if (b_hs) begin
            aw_acc <= 1'b0;
            w_acc  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_acc <= 1'b1;
            end
            if (w_hs) begin
                w_acc <= 1'b1;
            end
        end
    end

endmodule

// ==== src/axil_wr_interconnect_wrapper.sv ====
module axil_wr_interconnect_wrapper #(
    parameter  int                   NUMBER_MASTER = 2,
    parameter  int                   NUMBER_SLAVE  = 2,
    parameter  axil_xbar_pkg::addr_t ADDR_OFFSET [NUMBER_SLAVE] = '{32'h0000_0000,
                                                                     32'h1000_0000},
    parameter  axil_xbar_pkg::addr_t ADDR_RANGE  [NUMBER_SLAVE] = '{32'h0FFF_FFFF,
                                                                     32'h0FFF_FFFF},
    localparam int MIDX_W = (NUMBER_MASTER > 1) ? $clog2(NUMBER_MASTER) : 1
) (
    input  logic                     aclk,
    input  logic                     rst,

    ////////////////////////////////////////////////////////////
    // Master write channels
    ////////////////////////////////////////////////////////////

    input  axil_xbar_pkg::addr_t     m_axil_awaddr [NUMBER_MASTER],
    input  logic [NUMBER_MASTER-1:0] m_axil_awvalid,
    output logic [NUMBER_MASTER-1:0] m_axil_awready,
    input  axil_xbar_pkg::data_t     m_axil_wdata  [NUMBER_MASTER],
    input  axil_xbar_pkg::strb_t     m_axil_wstrb  [NUMBER_MASTER],
    input  logic [NUMBER_MASTER-1:0] m_axil_wvalid,
    output logic [NUMBER_MASTER-1:0] m_axil_wready,
    output axil_xbar_pkg::resp_t     m_axil_bresp  [NUMBER_MASTER],
    output logic [NUMBER_MASTER-1:0] m_axil_bvalid,
    input  logic [NUMBER_MASTER-1:0] m_axil_bready,

    ////////////////////////////////////////////////////////////
    // Slave write channels
    ////////////////////////////////////////////////////////////

    output axil_xbar_pkg::addr_t     s_axil_awaddr [NUMBER_SLAVE],
    output logic [NUMBER_SLAVE-1:0]  s_axil_awvalid,
    input  logic [NUMBER_SLAVE-1:0]  s_axil_awready,
    output axil_xbar_pkg::data_t     s_axil_wdata  [NUMBER_SLAVE],
    output axil_xbar_pkg::strb_t     s_axil_wstrb  [NUMBER_SLAVE],
    output logic [NUMBER_SLAVE-1:0]  s_axil_wvalid,
    input  logic [NUMBER_SLAVE-1:0]  s_axil_wready,
    input  axil_xbar_pkg::resp_t     s_axil_bresp  [NUMBER_SLAVE],
    input  logic [NUMBER_SLAVE-1:0]  s_axil_bvalid,
    output logic [NUMBER_SLAVE-1:0]  s_axil_bready
);

    // Arbiter to router
    logic                 grant_valid;
    logic [MIDX_W-1:0]    grant_idx;
    logic                 txn_done;

    // Router to decode-error slave
    axil_xbar_pkg::addr_t err_awaddr;
    logic                 err_awvalid;
    logic                 err_awready;
    axil_xbar_pkg::data_t err_wdata;
    axil_xbar_pkg::strb_t err_wstrb;
    logic                 err_wvalid;
    logic                 err_wready;
    axil_xbar_pkg::resp_t err_bresp;
    logic                 err_bvalid;
    logic                 err_bready;

    axil_wr_arbiter #(
        .NUMBER_MASTER(NUMBER_MASTER)
    ) axil_wr_arbiter_i (
        .aclk       (aclk),
        .rst        (rst),
        .m_awvalid  (m_axil_awvalid),
        .txn_done   (txn_done),
        .grant_valid(grant_valid),
        .grant_idx  (grant_idx)
    );

    axil_wr_router #(
        .NUMBER_MASTER(NUMBER_MASTER),
        .NUMBER_SLAVE (NUMBER_SLAVE),
        .ADDR_OFFSET  (ADDR_OFFSET),
        .ADDR_RANGE   (ADDR_RANGE)
    ) axil_wr_router_i (
        .*
    );

    axil_wr_decerr_slave axil_wr_decerr_slave_i (
        .aclk   (aclk),
        .rst    (rst),
        .awaddr (err_awaddr),
        .awvalid(err_awvalid),
        .awready(err_awready),
        .wdata  (err_wdata),
        .wstrb  (err_wstrb),
        .wvalid (err_wvalid),
        .wready (err_wready),
        .bresp  (err_bresp),
        .bvalid (err_bvalid),
        .bready (err_bready)
    );

endmodule

// ==== verif/axil_clk_gen.sv ====
module axil_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic aclk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        aclk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) aclk = ~aclk;
        end
    end

    // Released just after a rising edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1 rst = 1'b0;
    end

endmodule

// ==== verif/axil_wr_interconnect_tb.sv ====
module axil_wr_interconnect_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_ROWS   = 10;
    localparam int NO_SLAVE   = -1;

    typedef struct {
        bit                   pair;
        int                   mst;
        axil_xbar_pkg::addr_t addr;
        axil_xbar_pkg::data_t data;
        axil_xbar_pkg::strb_t strb;
        int                   exp_slv;
        axil_xbar_pkg::resp_t exp_resp;
        int                   bready_dly;
    } row_t;

    // A pair row starts together with the row after it and is expected to finish first
    row_t rows [NUM_ROWS] = '{
        '{1'b1, 0, 32'h0000_0010, 32'hA000_0001, 4'hF, 0, axil_xbar_pkg::RESP_OKAY,   0},
        '{1'b0, 1, 32'h1000_0020, 32'hEE00_0002, 4'hF, 1, axil_xbar_pkg::RESP_SLVERR, 0},
        '{1'b0, 0, 32'h0000_1234, 32'h1234_5678, 4'h3, 0, axil_xbar_pkg::RESP_OKAY,   0},
        '{1'b0, 1, 32'h1000_ABC0, 32'h8765_4321, 4'hC, 1, axil_xbar_pkg::RESP_OKAY,   1},
        '{1'b0, 0, 32'h8000_0000, 32'h0BAD_0004, 4'hF, NO_SLAVE,
          axil_xbar_pkg::RESP_DECERR, 0},
        '{1'b0, 1, 32'h1000_0040, 32'hEE00_0055, 4'hF, 1, axil_xbar_pkg::RESP_SLVERR, 0},
        '{1'b1, 0, 32'h0000_0080, 32'h5A5A_0006, 4'hF, 0, axil_xbar_pkg::RESP_OKAY,   5},
        '{1'b0, 1, 32'h1FFF_FFFC, 32'hEE00_0007, 4'h1, 1, axil_xbar_pkg::RESP_SLVERR, 2},
        '{1'b0, 1, 32'h0FFF_FFF0, 32'hEE00_0008, 4'hF, 0, axil_xbar_pkg::RESP_SLVERR, 0},
        '{1'b0, 0, 32'h2000_0000, 32'h0000_0009, 4'hF, NO_SLAVE,
          axil_xbar_pkg::RESP_DECERR, 3}
    };

    logic                 aclk;
    logic                 rst;

    axil_xbar_pkg::addr_t m_axil_awaddr [2];
    logic [1:0]           m_axil_awvalid;
    logic [1:0]           m_axil_awready;
    axil_xbar_pkg::data_t m_axil_wdata  [2];
    axil_xbar_pkg::strb_t m_axil_wstrb  [2];
    logic [1:0]           m_axil_wvalid;
    logic [1:0]           m_axil_wready;
    axil_xbar_pkg::resp_t m_axil_bresp  [2];
    logic [1:0]           m_axil_bvalid;
    logic [1:0]           m_axil_bready;

    axil_xbar_pkg::addr_t s_axil_awaddr [2];
    logic [1:0]           s_axil_awvalid;
    wire  [1:0]           s_axil_awready;
    axil_xbar_pkg::data_t s_axil_wdata  [2];
    axil_xbar_pkg::strb_t s_axil_wstrb  [2];
    logic [1:0]           s_axil_wvalid;
    wire  [1:0]           s_axil_wready;
    wire  axil_xbar_pkg::resp_t s_axil_bresp [2];
    wire  [1:0]           s_axil_bvalid;
    logic [1:0]           s_axil_bready;

    // What each slave model saw last
    wire  axil_xbar_pkg::addr_t rec_addr [2];
    wire  axil_xbar_pkg::data_t rec_data [2];
    wire  axil_xbar_pkg::strb_t rec_strb [2];
    wire  [31:0]          aw_cnt   [2];

    int                   dly_pool [64];
    int                   order_q  [$];
    int                   errors;
    int                   done_count;

    axil_clk_gen #(
        .PERIOD_NS   (CLK_PERIOD),
        .RESET_CYCLES(4)
    ) axil_clk_gen_i (
        .aclk(aclk),
        .rst (rst)
    );

    axil_wr_interconnect_wrapper #(
        .NUMBER_MASTER(2),
        .NUMBER_SLAVE (2)
    ) axil_wr_interconnect_wrapper_i (
        .*
    );

    ////////////////////////////////////////////////////////////
    // Slave models
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < 2; k++) begin : g_slave
        logic                 awready;
        logic                 wready;
        logic                 bvalid;
        axil_xbar_pkg::resp_t bresp;
        axil_xbar_pkg::addr_t last_addr;
        axil_xbar_pkg::data_t last_data;
        axil_xbar_pkg::strb_t last_strb;
        int                   aw_count;
        int                   draws;

        assign s_axil_awready[k] = awready;
        assign s_axil_wready[k]  = wready;
        assign s_axil_bvalid[k]  = bvalid;
        assign s_axil_bresp[k]   = bresp;
        assign rec_addr[k]       = last_addr;
        assign rec_data[k]       = last_data;
        assign rec_strb[k]       = last_strb;
        assign aw_cnt[k]         = aw_count;

        initial begin
            awready   = 1'b0;
            wready    = 1'b0;
            bvalid    = 1'b0;
            bresp     = axil_xbar_pkg::RESP_OKAY;
            last_addr = '0;
            last_data = '0;
            last_strb = '0;
            aw_count  = 0;
            draws     = 0;
            @(negedge rst);
            forever begin
                // AW beat after a random wait
                do @(negedge aclk); while (!s_axil_awvalid[k]);
                @(posedge aclk);
                #1;
                repeat (dly_pool[(k * 32 + draws) % 64]) begin
                    @(posedge aclk);
                    #1;
                end
                draws++;
                awready = 1'b1;
                @(negedge aclk);
                last_addr = s_axil_awaddr[k];
                aw_count++;
                @(posedge aclk);
                #1 awready = 1'b0;

                // W beat
                do @(negedge aclk); while (!s_axil_wvalid[k]);
                @(posedge aclk);
                #1;
                repeat (dly_pool[(k * 32 + draws) % 64]) begin
                    @(posedge aclk);
                    #1;
                end
                draws++;
                wready = 1'b1;
                @(negedge aclk);
                last_data = s_axil_wdata[k];
                last_strb = s_axil_wstrb[k];
                @(posedge aclk);
                #1 wready = 1'b0;

                // Tagged data 0xEE.. gets a slave error
                bvalid = 1'b1;
                bresp  = (last_data[31:24] == 8'hEE) ? axil_xbar_pkg::RESP_SLVERR
                                                      : axil_xbar_pkg::RESP_OKAY;
                do @(negedge aclk); while (!s_axil_bready[k]);
                @(posedge aclk);
                #1 bvalid = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks and master driver
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR: %s at %0t", msg, $time);
        errors++;
    endtask

    task automatic check_idle_outputs();
        if (m_axil_awready !== 2'b00) report_mismatch("m_axil_awready", m_axil_awready, 0);
        if (m_axil_wready !== 2'b00) report_mismatch("m_axil_wready", m_axil_wready, 0);
        if (m_axil_bvalid !== 2'b00) report_mismatch("m_axil_bvalid", m_axil_bvalid, 0);
        if (s_axil_awvalid !== 2'b00) report_mismatch("s_axil_awvalid", s_axil_awvalid, 0);
    endtask

    // Runs one write for a master from just after a rising edge
    task automatic drive_write(input int r);
        int                   m;
        bit                   aw_ok;
        bit                   w_ok;
        bit                   aw_hs;
        bit                   w_hs;
        axil_xbar_pkg::resp_t held_resp;
        m = rows[r].mst;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        m_axil_awaddr[m]  = rows[r].addr;
        m_axil_wdata[m]   = rows[r].data;
        m_axil_wstrb[m]   = rows[r].strb;
        m_axil_awvalid[m] = 1'b1;
        m_axil_wvalid[m]  = 1'b1;
        while (!(aw_ok && w_ok)) begin
            @(negedge aclk);
            aw_hs = m_axil_awvalid[m] && m_axil_awready[m];
            w_hs  = m_axil_wvalid[m] && m_axil_wready[m];
            @(posedge aclk);
            #1;
            if (aw_hs) begin
                m_axil_awvalid[m] = 1'b0;
                aw_ok = 1'b1;
            end
            if (w_hs) begin
                m_axil_wvalid[m] = 1'b0;
                w_ok = 1'b1;
            end
        end
        do @(negedge aclk); while (!m_axil_bvalid[m]);
        held_resp = m_axil_bresp[m];
        // Response holds and no other master gets in under back-pressure
        repeat (rows[r].bready_dly) begin
            @(negedge aclk);
            if (!m_axil_bvalid[m] || m_axil_bresp[m] !== held_resp) begin
                report_failure($sformatf("B response of master %0d changed under bready low",
                                         m));
            end
            if (m_axil_awready[1 - m] !== 1'b0) begin
                report_failure($sformatf("master %0d got awready during a held B", 1 - m));
            end
        end
        @(posedge aclk);
        #1 m_axil_bready[m] = 1'b1;
        @(negedge aclk);
        if (m_axil_bresp[m] !== rows[r].exp_resp) begin
            report_mismatch($sformatf("m_axil_bresp[%0d]", m), m_axil_bresp[m],
                            rows[r].exp_resp);
        end
        order_q.push_back(m);
        done_count++;
        @(posedge aclk);
        #1 m_axil_bready[m] = 1'b0;
    endtask

    task automatic run_group(input int first, input int n);
        int base [2];
        int inc  [2];
        int k;
        for (int s = 0; s < 2; s++) begin
            base[s] = aw_cnt[s];
            inc[s]  = 0;
        end
        order_q.delete();
        @(posedge aclk);
        #1;
        if (n == 2) begin
            fork
                drive_write(first);
                drive_write(first + 1);
            join
        end else begin
            drive_write(first);
        end
        for (int j = first; j < first + n; j++) begin
            if (order_q[j - first] != rows[j].mst) begin
                report_failure($sformatf("write %0d finished by master %0d, expected master %0d",
                                         j, order_q[j - first], rows[j].mst));
            end
            k = rows[j].exp_slv;
            if (k != NO_SLAVE) begin
                inc[k]++;
                if (rec_addr[k] !== rows[j].addr) begin
                    report_mismatch($sformatf("s_axil_awaddr[%0d]", k), rec_addr[k],
                                    rows[j].addr);
                end
                if (rec_data[k] !== rows[j].data) begin
                    report_mismatch($sformatf("s_axil_wdata[%0d]", k), rec_data[k],
                                    rows[j].data);
                end
                if (rec_strb[k] !== rows[j].strb) begin
                    report_mismatch($sformatf("s_axil_wstrb[%0d]", k), rec_strb[k],
                                    rows[j].strb);
                end
            end
        end
        for (int s = 0; s < 2; s++) begin
            if (aw_cnt[s] != base[s] + inc[s]) begin
                report_failure($sformatf("slave %0d took %0d AW beats, expected %0d",
                                         s, aw_cnt[s] - base[s], inc[s]));
            end
        end
    endtask

    initial begin
        int i;
        errors     = 0;
        done_count = 0;
        for (int m = 0; m < 2; m++) begin
            m_axil_awaddr[m] = '0;
            m_axil_wdata[m]  = '0;
            m_axil_wstrb[m]  = '0;
        end
        m_axil_awvalid = '0;
        m_axil_wvalid  = '0;
        m_axil_bready  = '0;
        void'($urandom(32'h249388f2));
        for (int j = 0; j < 64; j++) begin
            dly_pool[j] = $urandom_range(3, 0);
        end

        // Quiet outputs in reset and one cycle past it
        @(negedge aclk);
        while (rst) begin
            check_idle_outputs();
            @(negedge aclk);
        end
        check_idle_outputs();
        @(negedge aclk);
        check_idle_outputs();

        i = 0;
        while (i < NUM_ROWS) begin
            if (rows[i].pair) begin
                run_group(i, 2);
                i = i + 2;
            end else begin
                run_group(i, 1);
                i = i + 1;
            end
        end
        repeat (2) @(posedge aclk);
        $display("Writes completed: %0d of %0d, errors: %0d", done_count, NUM_ROWS, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        axil_xbar_pkg::router_state_t rt_state;
        #((NUM_ROWS * 50 + 100) * CLK_PERIOD);
        rt_state = axil_wr_interconnect_wrapper_i.axil_wr_router_i.state;
        $display("Timeout: only %0d writes completed, router stuck in %s",
                 done_count, rt_state.name());
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== axil_wr_interconnect_wrapper.f ====
src/axil_xbar_pkg.sv
src/axil_wr_arbiter.sv
src/axil_wr_router.sv
src/axil_wr_decerr_slave.sv
src/axil_wr_interconnect_wrapper.sv
verif/axil_clk_gen.sv
verif/axil_wr_interconnect_tb.sv

// ==== Bender.yml ====
package:
  name: axil_wr_interconnect

sources:
  - files:
      - src/axil_xbar_pkg.sv
      - src/axil_wr_arbiter.sv
      - src/axil_wr_router.sv
      - src/axil_wr_decerr_slave.sv
      - src/axil_wr_interconnect_wrapper.sv
  - target: test
    files:
      - verif/axil_clk_gen.sv
      - verif/axil_wr_interconnect_tb.sv
